// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_single_cycle
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Run failed"; exit 1; fi; \
	if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Run ended without a result"; exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sll    = 4'd6,
        alu_srl    = 4'd7,
        alu_sra    = 4'd8,
        alu_pass_b = 4'd9
    } alu_op_e;

    typedef enum logic [2:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    reg_write;
        logic    mem_write;
        logic    mem_to_reg;
        logic    branch;
        logic    branch_ne;
        logic    jump;
        logic    illegal;
    } ctrl_t;

    // One record per executed instruction
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
        logic            rd_we;
        logic [4:0]      rd;
        logic [xlen-1:0] rd_data;
        logic            mem_we;
        logic [xlen-1:0] mem_addr;
        logic [xlen-1:0] mem_data;
    } retire_t;

endpackage

`default_nettype wire

// File: flist.f
common/rv_pkg.sv
source/instr_mem.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/data_mem.sv
source/single_cycle_core.sv
test/core_properties.sv
test/tb_single_cycle.sv

// File: source/alu.sv
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::ctrl_t           ctrl,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       operands_equal;
    logic       less_signed;

    assign shamt       = b[4:0];
    assign less_signed = $signed(a) < $signed(b);

    always_comb begin
        case (ctrl.alu_op)
            alu_add: begin
                result = a + b;
            end
            alu_sub: begin
                result = a - b;
            end
            alu_and: begin
                result = a & b;
            end
            alu_or: begin
                result = a | b;
            end
            alu_xor: begin
                result = a ^ b;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, less_signed};
            end
            alu_sll: begin
                result = a << shamt;
            end
            alu_srl: begin
                result = a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(a) >>> shamt);
            end
            alu_pass_b: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branches run with rs2 on operand b, so a and b are the two sources
    assign operands_equal = (a == b);
    assign taken          = ctrl.branch && (operands_equal ^ ctrl.branch_ne);

endmodule

`default_nettype wire

// File: source/data_mem.sv
`default_nettype none

module data_mem #(
    parameter int DMEM_DEPTH = 256
) (
    input  logic                    clk,
    input  logic                    we,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    output logic [rv_pkg::xlen-1:0] rdata
);
    import rv_pkg::*;

    localparam int aw = $clog2(DMEM_DEPTH);

    // Contents start at zero and survive reset
    logic [xlen-1:0] mem [DMEM_DEPTH] = '{default: '0};
    logic [aw-1:0]   idx;

    // Word index, upper address bits wrap
    assign idx = addr[aw+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];

endmodule

`default_nettype wire

// File: source/decoder.sv
`default_nettype none

module decoder (
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [4:0]              rd,
    output logic [rv_pkg::xlen-1:0] imm,
    output rv_pkg::ctrl_t           ctrl
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_sel_e   imm_sel;

    assign opcode = opcode_e'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // Sign-extended immediates, bit 31 is always the sign
    always_comb begin
        case (imm_sel)
            imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
            imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_u:   imm = {instr[31:12], 12'b0};
            default: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        imm_sel     = imm_i;
        case (opcode)
            opc_op: begin
                ctrl.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'h00, 3'b111}: ctrl.alu_op = alu_and;
                    {7'h00, 3'b110}: ctrl.alu_op = alu_or;
                    {7'h00, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'h00, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'h00, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'h00, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'h20, 3'b101}: ctrl.alu_op = alu_sra;
                    default:         ctrl.illegal = 1'b1;
                endcase
            end
            opc_op_imm: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = alu_add;
                    3'b111:  ctrl.alu_op = alu_and;
                    3'b110:  ctrl.alu_op = alu_or;
                    3'b100:  ctrl.alu_op = alu_xor;
                    3'b010:  ctrl.alu_op = alu_slt;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opc_load: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
                ctrl.illegal     = (funct3 != 3'b010);
            end
            opc_store: begin
                imm_sel          = imm_s;
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                ctrl.illegal     = (funct3 != 3'b010);
            end
            opc_branch: begin
                imm_sel        = imm_b;
                ctrl.alu_op    = alu_sub;
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                ctrl.illegal   = (funct3[2:1] != 2'b00);
            end
            opc_lui: begin
                imm_sel          = imm_u;
                ctrl.alu_op      = alu_pass_b;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            opc_jal: begin
                imm_sel          = imm_j;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.jump        = 1'b1;
            end
            default: ctrl.illegal = 1'b1;
        endcase
        // Unsupported encodings retire as a no-op
        if (ctrl.illegal) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_unit.sv
`default_nettype none

module fetch_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    taken,
    input  logic                    jump,
    input  logic [rv_pkg::xlen-1:0] imm,
    output logic [rv_pkg::xlen-1:0] pc
);
    import rv_pkg::*;

    logic [xlen-1:0] pc_seq;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] pc_next;

    assign pc_seq    = pc + xlen'(4);
    // Branch and JAL offsets are both relative to the current PC
    assign pc_target = pc + imm;

    always_comb begin
        if (taken || jump) begin
            pc_next = pc_target;
        end else begin
            pc_next = pc_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: source/instr_mem.sv
`default_nettype none

module instr_mem #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [rv_pkg::xlen-1:0]       prog_data,
    input  logic [rv_pkg::xlen-1:0]       pc,
    output logic [rv_pkg::xlen-1:0]       instr
);
    import rv_pkg::*;

    localparam int aw = $clog2(IMEM_DEPTH);

    logic [xlen-1:0] mem [IMEM_DEPTH];
    logic [xlen-3:0] word_idx;

    // Program load only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset && prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign word_idx = pc[xlen-1:2];

    // Fetch beyond the array returns a NOP
    assign instr = (word_idx < IMEM_DEPTH) ? mem[word_idx[aw-1:0]] : nop_instr;

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [4:0]              rs1,
    input  logic [4:0]              rs2,
    output logic [rv_pkg::xlen-1:0] rs1_data,
    output logic [rv_pkg::xlen-1:0] rs2_data,
    input  logic                    we,
    input  logic [4:0]              rd,
    input  logic [rv_pkg::xlen-1:0] wdata
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // No bypass, a read in the writing cycle sees the old value
    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/single_cycle_core.sv
`default_nettype none

module single_cycle_core #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [rv_pkg::xlen-1:0]       prog_data,
    output rv_pkg::retire_t               retire
);
    import rv_pkg::*;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_a;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] result;
    logic [xlen-1:0] rdata;
    logic [xlen-1:0] wb_data;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            taken;
    logic            dmem_we;
    ctrl_t           ctrl;

    instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_instr_mem (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .pc(pc), .instr(instr)
    );

    fetch_unit u_fetch_unit (
        .clk(clk), .reset(reset), .taken(taken), .jump(ctrl.jump), .imm(imm), .pc(pc)
    );

    decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .ctrl(ctrl)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .we(ctrl.reg_write), .rd(rd), .wdata(wb_data)
    );

    // JAL computes off the PC, everything else off rs1
    assign alu_a = ctrl.jump ? pc : rs1_data;
    assign alu_b = ctrl.alu_src_imm ? imm : rs2_data;

    alu u_alu (.a(alu_a), .b(alu_b), .ctrl(ctrl), .result(result), .taken(taken));

    // Keep stores from the instruction at PC 0 out while the program loads
    assign dmem_we = ctrl.mem_write && !reset;

    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_data_mem (
        .clk(clk), .we(dmem_we), .addr(result), .wdata(rs2_data), .rdata(rdata)
    );

    assign pc_plus4 = pc + xlen'(4);
    assign wb_data  = ctrl.jump ? pc_plus4 : (ctrl.mem_to_reg ? rdata : result);

    always_comb begin
        retire.valid    = !reset;
        retire.pc       = pc;
        retire.instr    = instr;
        retire.rd_we    = ctrl.reg_write && (rd != 5'd0);
        retire.rd       = rd;
        retire.rd_data  = wb_data;
        retire.mem_we   = dmem_we;
        retire.mem_addr = result;
        retire.mem_data = rs2_data;
    end

endmodule

`default_nettype wire

// File: test/core_properties.sv
`default_nettype none

module core_properties (
    input logic            clk,
    input logic            reset,
    input rv_pkg::retire_t retire
);
    import rv_pkg::*;

    logic flow_change;

    // Branches and JAL are the only instructions that redirect the PC
    assign flow_change = (retire.instr[6:0] == opc_branch) || (retire.instr[6:0] == opc_jal);

    valid_low_in_reset: assert property (@(posedge clk) reset |-> !retire.valid)
        else $error("retire valid while reset is high");

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        !(retire.rd_we && (retire.rd == 5'd0)))
        else $error("register write reported for x0");

    pc_aligned: assert property (@(posedge clk) disable iff (reset) retire.pc[1:0] == 2'b00)
        else $error("retired PC is not word aligned");

    pc_sequential: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && !flow_change) |=> (retire.pc == $past(retire.pc) + 32'd4))
        else $error("PC did not advance by 4 after a sequential instruction");

endmodule

bind single_cycle_core core_properties core_properties_inst (
    .clk(clk), .reset(reset), .retire(retire)
);

`default_nettype wire

// File: test/tb_single_cycle.sv
`default_nettype none

module tb_single_cycle;
    import rv_pkg::*;

    localparam int IMEM_DEPTH   = 256;
    localparam int DMEM_DEPTH   = 256;
    localparam int aw           = $clog2(IMEM_DEPTH);
    localparam int prog_len     = 121;
    localparam int reset_cycles = prog_len + 4;
    localparam int cycle_limit  = 2 * prog_len + reset_cycles;
    localparam logic [31:0] self_loop = 32'h0000_006f;

    logic          clk;
    logic          reset;
    logic          prog_we;
    logic [aw-1:0] prog_addr;
    logic [31:0]   prog_data;
    retire_t       retire;

    // Reference model state
    logic [31:0] prog [prog_len];
    logic [31:0] m_regs [32];
    logic [31:0] m_mem [DMEM_DEPTH];
    logic [31:0] m_pc;
    logic        exp_rd_we;
    logic [4:0]  exp_rd;
    logic [31:0] exp_rd_data;
    logic        exp_mem_we;
    logic [31:0] exp_mem_addr;
    logic [31:0] exp_mem_data;
    logic        done;
    int          cycles;

    single_cycle_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) single_cycle_core_inst (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "compare failed");
        end
    endtask

    function automatic logic [31:0] random_instr(input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm12;
        logic [11:0] off;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [6:0]  f7;
        logic [2:0]  f3;
        int unsigned kind;
        rd    = (($urandom % 8) == 0) ? 5'd0 : 5'(1 + $urandom % 15);
        rs1   = 5'($urandom % 16);
        rs2   = 5'($urandom % 16);
        imm12 = 12'($urandom);
        // Sixteen spread word addresses, so loads often hit earlier stores
        off   = 12'(($urandom % 16) * 68);
        boff  = 13'((2 + $urandom % 5) * 4);
        joff  = 21'(boff);
        // Near the end only straight-line code, so nothing jumps past the self-loop
        kind  = (idx + 6 > prog_len - 1) ? $urandom % 8 : $urandom % 10;
        f7    = 7'h00;
        case ($urandom % 9)
            0: f3 = 3'd0;
            1: {f7, f3} = {7'h20, 3'd0};
            2: f3 = 3'd7;
            3: f3 = 3'd6;
            4: f3 = 3'd4;
            5: f3 = 3'd2;
            6: f3 = 3'd1;
            7: f3 = 3'd5;
            default: {f7, f3} = {7'h20, 3'd5};
        endcase
        case (kind)
            0, 1, 2: return {f7, rs2, rs1, f3, rd, 7'h33};
            3, 4: begin
                // ADDI, ANDI, ORI, XORI, SLTI only
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    f3 = 3'd0;
                end
                return {imm12, rs1, f3, rd, 7'h13};
            end
            5: return {20'($urandom), rd, 7'h37};
            6: return {off, 5'd0, 3'd2, rd, 7'h03};
            7: return {off[11:5], rs2, 5'd0, 3'd2, off[4:0], 7'h23};
            8: return {boff[12], boff[10:5], rs2, rs1, 2'b00, 1'($urandom), boff[4:1], boff[11],
                       7'h63};
            default: return {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'h6f};
        endcase
    endfunction

    // Executes the instruction at m_pc per the RV32I rules
    task automatic model_step();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic        wr;
        ins          = prog[int'(m_pc >> 2)];
        a            = m_regs[ins[19:15]];
        b            = m_regs[ins[24:20]];
        imm_i        = {{20{ins[31]}}, ins[31:20]};
        res          = '0;
        wr           = 1'b0;
        next_pc      = m_pc + 32'd4;
        exp_mem_we   = 1'b0;
        exp_mem_addr = '0;
        exp_mem_data = '0;
        // I-type ALU ops take the immediate in place of rs2
        if (ins[6:0] == 7'h13) begin
            b = imm_i;
        end
        case (ins[6:0])
            7'h33, 7'h13: begin
                wr = 1'b1;
                case (ins[14:12])
                    3'd0: res = (ins[6:0] == 7'h33 && ins[30]) ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'd4: res = a ^ b;
                    3'd5: res = ins[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: res = a | b;
                    default: res = a & b;
                endcase
            end
            7'h03: begin
                wr  = 1'b1;
                res = m_mem[((a + imm_i) >> 2) % DMEM_DEPTH];
            end
            7'h23: begin
                exp_mem_we   = 1'b1;
                exp_mem_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                exp_mem_data = b;
                m_mem[(exp_mem_addr >> 2) % DMEM_DEPTH] = b;
            end
            7'h63: begin
                if ((a == b) != ins[12]) begin
                    next_pc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'h37: begin
                wr  = 1'b1;
                res = {ins[31:12], 12'b0};
            end
            7'h6f: begin
                wr      = 1'b1;
                res     = m_pc + 32'd4;
                next_pc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: wr = 1'b0;
        endcase
        exp_rd      = ins[11:7];
        exp_rd_we   = wr && (exp_rd != 5'd0);
        exp_rd_data = res;
        if (exp_rd_we) begin
            m_regs[exp_rd] = res;
        end
        m_pc = next_pc;
    endtask

    // Retire is combinational, so sample it mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            check(32'(retire.valid), 32'd0, "retire valid during reset");
        end else if (!done) begin
            check(32'(retire.valid), 32'd1, "retire valid");
            check(retire.pc, m_pc, "retire pc");
            check(retire.instr, prog[int'(m_pc >> 2)], "retire instr");
            model_step();
            check(32'(retire.rd_we), 32'(exp_rd_we), "rd_we");
            if (exp_rd_we) begin
                check(32'(retire.rd), 32'(exp_rd), "rd");
                check(retire.rd_data, exp_rd_data, "rd_data");
            end
            check(32'(retire.mem_we), 32'(exp_mem_we), "mem_we");
            if (exp_mem_we) begin
                check(retire.mem_addr, exp_mem_addr, "mem_addr");
                check(retire.mem_data, exp_mem_data, "mem_data");
            end
            if (retire.instr == self_loop) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        void'($urandom(32'hf2c46693));
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        done      = 1'b0;
        cycles    = 0;
        m_pc      = '0;
        for (int i = 0; i < 32; i++) begin
            m_regs[i] = '0;
        end
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
        for (int i = 0; i < prog_len - 1; i++) begin
            prog[i] = random_instr(i);
        end
        prog[prog_len-1] = self_loop;
        // Program load while reset is held
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= aw'(i);
            prog_data <= prog[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        while (!done && cycles < cycle_limit) begin
            @(posedge clk);
        end
        if (done) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Timeout: self-loop not reached within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

endmodule

`default_nettype wire
